//--- flist.f
pll_reconfig_pkg.sv
pll_user_regs.sv
pll_l2p_store.sv
pll_clock_decode.sv
pll_rmw_sequencer.sv
pll_reconfig_top.sv
tb_ctrl_responder.sv
tb_pll_reconfig.sv

//--- pll_clock_decode.sv
`timescale 1ns/1ps

module pll_clock_decode (
  input  pll_reconfig_pkg::refclk_id_t   refclk_id,
  input  pll_reconfig_pkg::cgb_id_t      cgb_id,
  output pll_reconfig_pkg::refclk_cfg_t  refclk_cfg,
  output pll_reconfig_pkg::cgb_cfg_t     cgb_cfg
);

  //////////////////////////////////////////////////////////////////////
  // Refclk id to IQ clock select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    refclk_cfg = '0;  // PCIe mode never set here
    case (refclk_id) inside
      [5'd0:5'd10]:
        refclk_cfg.iq_clk_sel = 8'(refclk_id) + 8'd1;  // Reference IQ clocks
      [5'd11:5'd21]:
        refclk_cfg.iq_clk_sel = {4'(refclk_id - 5'd10), 4'h0};  // RX IQ clocks
      5'd22:
        refclk_cfg.rrefclk_sel = 1'b1;  // Core clock
      5'd23, 5'd25:
        refclk_cfg.iq_clk_sel = 8'h00;
      5'd24:
        refclk_cfg.iq_clk_sel = 8'h0C;
      default:
        refclk_cfg.iq_clk_sel = 8'h01;
    endcase
  end

  // CGB select straight from the table
  assign cgb_cfg = pll_reconfig_pkg::CGB_DECODE[cgb_id];

endmodule

//--- pll_l2p_store.sv
`timescale 1ns/1ps

module pll_l2p_store (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            rom_done,
  input  pll_reconfig_pkg::pll_kind_e     kind,
  input  pll_reconfig_pkg::refclk_rom_t   ctrl_rdata,
  input  pll_reconfig_pkg::logical_idx_t  logical_idx,
  output pll_reconfig_pkg::refclk_rom_t   refclk_rom,
  output pll_reconfig_pkg::cgb_rom_t      cgb_rom,
  output pll_reconfig_pkg::refclk_id_t    refclk_id,
  output pll_reconfig_pkg::cgb_id_t       cgb_id
);

  pll_reconfig_pkg::logical_idx_t slot;

  // Out of range indexes use slot 0
  assign slot = (logical_idx < pll_reconfig_pkg::NUM_LOGICAL) ? logical_idx : '0;

  //////////////////////////////////////////////////////////////////////
  // ROM word capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      refclk_rom <= '0;
      cgb_rom    <= '0;
    end else if (rom_done) begin
      if (kind == pll_reconfig_pkg::PLL_CGB)
        cgb_rom <= ctrl_rdata[pll_reconfig_pkg::CGB_ROM_W-1:0];
      else
        refclk_rom <= ctrl_rdata;
    end
  end

  // Five packed ids per word, slot 0 at the bottom
  assign refclk_id = refclk_rom[slot*pll_reconfig_pkg::REFCLK_ID_W +:
                                pll_reconfig_pkg::REFCLK_ID_W];
  assign cgb_id    = cgb_rom[slot*pll_reconfig_pkg::CGB_ID_W +:
                             pll_reconfig_pkg::CGB_ID_W];

endmodule

//--- pll_reconfig_pkg.sv
package pll_reconfig_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and plain vector types
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NUM_LOGICAL  = 5;
  localparam int unsigned REFCLK_ID_W  = 5;
  localparam int unsigned CGB_ID_W     = 4;
  localparam int unsigned REFCLK_ROM_W = NUM_LOGICAL * REFCLK_ID_W;  // 25 bit L2P word
  localparam int unsigned CGB_ROM_W    = NUM_LOGICAL * CGB_ID_W;     // 20 bit L2P word
  localparam int unsigned CTRL_WDATA_W = 32;

  typedef logic [2:0]              uif_addr_t;
  typedef logic [2:0]              logical_idx_t;
  typedef logic [9:0]              lch_t;
  typedef logic [11:0]             ctrl_addr_t;
  typedef logic [15:0]             dprio_word_t;
  typedef logic [REFCLK_ID_W-1:0]  refclk_id_t;
  typedef logic [CGB_ID_W-1:0]     cgb_id_t;
  typedef logic [REFCLK_ROM_W-1:0] refclk_rom_t;
  typedef logic [CGB_ROM_W-1:0]    cgb_rom_t;
  typedef logic [CTRL_WDATA_W-1:0] ctrl_data_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and modes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    UIF_MODE_RD = 3'd0,
    UIF_MODE_WR = 3'd1
  } uif_mode_e;

  typedef enum logic [2:0] {
    CTRL_OP_RD     = 3'd0,
    CTRL_OP_WR     = 3'd1,
    CTRL_OP_ROM_RD = 3'd4
  } ctrl_op_e;

  typedef enum logic {
    PLL_REFCLK = 1'b0,
    PLL_CGB    = 1'b1
  } pll_kind_e;

  // ROM word select and DPRIO offsets
  localparam ctrl_addr_t ROM_SEL_REFCLK    = 12'd1;
  localparam ctrl_addr_t ROM_SEL_CGB       = 12'd2;
  localparam ctrl_addr_t DPRIO_REFIQ_OFST  = 12'h03A;  // Refclk word 0
  localparam ctrl_addr_t DPRIO_RREF_OFST   = 12'h017;  // Refclk word 1
  localparam ctrl_addr_t DPRIO_CGB_OFST    = 12'h030;  // CGB word 0
  localparam ctrl_addr_t DPRIO_CLKNET_OFST = 12'h031;  // CGB word 1

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       rrefclk_sel;
    logic       pcie_mode;
    logic [7:0] iq_clk_sel;
  } refclk_cfg_t;

  typedef struct packed {
    logic [1:0] x_en;
    logic       clknet_in_en;
    logic [5:0] clk_sel;
  } cgb_cfg_t;

  typedef struct packed {
    pll_kind_e kind;
    logic      l2p_only;  // ROM read only, no RMW
  } switch_req_t;

  typedef struct packed {
    logic       go;
    ctrl_op_e   opcode;
    logic       lock;
    lch_t       lch;
    ctrl_addr_t addr;
    ctrl_data_t wdata;
  } ctrl_req_t;

  // CGB id to PMA select, unlisted ids take the local channel setting
  localparam cgb_cfg_t CGB_DECODE [16] = '{
    '{2'd0, 1'b0, 6'h2C},  // 0  local TX PLL
    '{2'd0, 1'b0, 6'h13},  // 1
    '{2'd0, 1'b0, 6'h20},  // 2
    '{2'd0, 1'b0, 6'h2C},
    '{2'd0, 1'b0, 6'h2C},
    '{2'd0, 1'b0, 6'h12},  // 5  fractional PLL
    '{2'd0, 1'b0, 6'h10},  // 6  segmented up
    '{2'd0, 1'b0, 6'h11},  // 7  segmented down
    '{2'd2, 1'b1, 6'h28},  // 8  x6 up
    '{2'd1, 1'b1, 6'h24},  // 9  x6 down
    '{2'd0, 1'b1, 6'h24},  // 10 xN up
    '{2'd1, 1'b1, 6'h28},  // 11
    '{2'd0, 1'b0, 6'h2C},
    '{2'd0, 1'b0, 6'h2C},
    '{2'd0, 1'b0, 6'h2C},
    '{2'd0, 1'b0, 6'h2C}
  };

endpackage

//--- pll_reconfig_top.sv
`timescale 1ns/1ps

module pll_reconfig_top #(
  parameter int UIF_DATA_WIDTH  = 32,
  parameter int CTRL_DATA_WIDTH = 32
) (
  input  logic                          clk,
  input  logic                          reset,
  // User register port
  input  logic                          uif_go,
  input  pll_reconfig_pkg::uif_mode_e   uif_mode,
  input  pll_reconfig_pkg::uif_addr_t   uif_addr,
  input  logic [UIF_DATA_WIDTH-1:0]     uif_wdata,
  input  pll_reconfig_pkg::lch_t        uif_lch,
  output logic                          uif_busy,
  output logic [UIF_DATA_WIDTH-1:0]     uif_rdata,
  output logic                          uif_addr_err,
  // Basic block control port
  input  logic                          ctrl_wait,
  input  logic [CTRL_DATA_WIDTH-1:0]    ctrl_rdata,
  output pll_reconfig_pkg::ctrl_req_t   ctrl
);

  logic                           start;
  logic                           rom_done;
  pll_reconfig_pkg::switch_req_t  req;
  pll_reconfig_pkg::logical_idx_t logical_idx;
  pll_reconfig_pkg::refclk_rom_t  refclk_rom;
  pll_reconfig_pkg::cgb_rom_t     cgb_rom;
  pll_reconfig_pkg::refclk_id_t   refclk_id;
  pll_reconfig_pkg::cgb_id_t      cgb_id;
  pll_reconfig_pkg::refclk_cfg_t  refclk_cfg;
  pll_reconfig_pkg::cgb_cfg_t     cgb_cfg;

  pll_user_regs #(
    .UIF_DATA_WIDTH (UIF_DATA_WIDTH)
  ) u_user_regs (
    .clk          (clk),
    .reset        (reset),
    .uif_go       (uif_go),
    .uif_mode     (uif_mode),
    .uif_addr     (uif_addr),
    .uif_wdata    (uif_wdata),
    .refclk_rom   (refclk_rom),
    .cgb_rom      (cgb_rom),
    .uif_rdata    (uif_rdata),
    .uif_addr_err (uif_addr_err),
    .start        (start),
    .req          (req),
    .logical_idx  (logical_idx)
  );

  // Widest L2P word is the refclk one
  pll_l2p_store u_l2p_store (
    .clk         (clk),
    .reset       (reset),
    .rom_done    (rom_done),
    .kind        (req.kind),
    .ctrl_rdata  (ctrl_rdata[pll_reconfig_pkg::REFCLK_ROM_W-1:0]),
    .logical_idx (logical_idx),
    .refclk_rom  (refclk_rom),
    .cgb_rom     (cgb_rom),
    .refclk_id   (refclk_id),
    .cgb_id      (cgb_id)
  );

  pll_clock_decode u_clock_decode (
    .refclk_id  (refclk_id),
    .cgb_id     (cgb_id),
    .refclk_cfg (refclk_cfg),
    .cgb_cfg    (cgb_cfg)
  );

  pll_rmw_sequencer #(
    .CTRL_DATA_WIDTH (CTRL_DATA_WIDTH)
  ) u_rmw_sequencer (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .req        (req),
    .uif_lch    (uif_lch),
    .refclk_cfg (refclk_cfg),
    .cgb_cfg    (cgb_cfg),
    .ctrl_wait  (ctrl_wait),
    .ctrl_rdata (ctrl_rdata),
    .uif_busy   (uif_busy),
    .rom_done   (rom_done),
    .ctrl       (ctrl)
  );

endmodule

//--- pll_rmw_sequencer.sv
`timescale 1ns/1ps

module pll_rmw_sequencer #(
  parameter int CTRL_DATA_WIDTH = 32
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           start,
  input  pll_reconfig_pkg::switch_req_t  req,
  input  pll_reconfig_pkg::lch_t         uif_lch,
  input  pll_reconfig_pkg::refclk_cfg_t  refclk_cfg,
  input  pll_reconfig_pkg::cgb_cfg_t     cgb_cfg,
  input  logic                           ctrl_wait,
  input  logic [CTRL_DATA_WIDTH-1:0]     ctrl_rdata,
  output logic                           uif_busy,
  output logic                           rom_done,
  output pll_reconfig_pkg::ctrl_req_t    ctrl
);

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_ROM,
    SEQ_READ,
    SEQ_WRITE,
    SEQ_HOLD,   // Cycle after go
    SEQ_ACK     // Wait for ctrl_wait to drop
  } seq_state_e;

  seq_state_e                     state;
  pll_reconfig_pkg::pll_kind_e    kind_q;
  logic                           l2p_only_q;
  logic                           word_q;     // RMW word 0 then 1
  pll_reconfig_pkg::dprio_word_t  saved;
  pll_reconfig_pkg::dprio_word_t  merged;
  pll_reconfig_pkg::ctrl_addr_t   word_addr;

  assign uif_busy = start || (state != SEQ_IDLE);
  assign rom_done = (state == SEQ_ACK) && !ctrl_wait &&
                    (ctrl.opcode == pll_reconfig_pkg::CTRL_OP_ROM_RD);

  //////////////////////////////////////////////////////////////////////
  // DPRIO word address and merge
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (kind_q == pll_reconfig_pkg::PLL_CGB)
      word_addr = word_q ? pll_reconfig_pkg::DPRIO_CLKNET_OFST : pll_reconfig_pkg::DPRIO_CGB_OFST;
    else
      word_addr = word_q ? pll_reconfig_pkg::DPRIO_RREF_OFST : pll_reconfig_pkg::DPRIO_REFIQ_OFST;
  end

  always_comb begin
    case ({kind_q, word_q})
      2'b00:   merged = {saved[15:11], refclk_cfg.iq_clk_sel, saved[2:0]};
      2'b01:   merged = {refclk_cfg.rrefclk_sel, saved[14:6], refclk_cfg.pcie_mode,
                         saved[4:0]};
      2'b10:   merged = {saved[15:13], cgb_cfg.x_en, saved[10:6], cgb_cfg.clk_sel};
      default: merged = {saved[15:10], cgb_cfg.clknet_in_en, saved[8:0]};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= SEQ_IDLE;
      kind_q     <= pll_reconfig_pkg::PLL_REFCLK;
      l2p_only_q <= 1'b0;
      word_q     <= 1'b0;
      saved      <= '0;
      ctrl       <= '0;
    end else begin
      ctrl.go <= 1'b0;  // Single cycle pulse
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            state      <= SEQ_ROM;
            kind_q     <= req.kind;
            l2p_only_q <= req.l2p_only;
            word_q     <= 1'b0;
            ctrl.lch   <= uif_lch;
          end
        end
        SEQ_ROM: begin
          ctrl.go     <= 1'b1;
          ctrl.opcode <= pll_reconfig_pkg::CTRL_OP_ROM_RD;
          ctrl.lock   <= !l2p_only_q;
          ctrl.addr   <= (kind_q == pll_reconfig_pkg::PLL_CGB) ?
                         pll_reconfig_pkg::ROM_SEL_CGB : pll_reconfig_pkg::ROM_SEL_REFCLK;
          ctrl.wdata  <= '0;
          state       <= SEQ_HOLD;
        end
        SEQ_READ: begin
          ctrl.go     <= 1'b1;
          ctrl.opcode <= pll_reconfig_pkg::CTRL_OP_RD;
          ctrl.lock   <= 1'b1;
          ctrl.addr   <= word_addr;
          ctrl.wdata  <= '0;
          state       <= SEQ_HOLD;
        end
        SEQ_WRITE: begin
          ctrl.go     <= 1'b1;
          ctrl.opcode <= pll_reconfig_pkg::CTRL_OP_WR;
          ctrl.lock   <= !word_q;  // Released on the final write
          ctrl.addr   <= word_addr;
          ctrl.wdata  <= pll_reconfig_pkg::ctrl_data_t'(merged);
          state       <= SEQ_HOLD;
        end
        SEQ_HOLD: state <= SEQ_ACK;
        SEQ_ACK: begin
          if (!ctrl_wait) begin
            case (ctrl.opcode)
              pll_reconfig_pkg::CTRL_OP_ROM_RD:
                state <= l2p_only_q ? SEQ_IDLE : SEQ_READ;
              pll_reconfig_pkg::CTRL_OP_RD: begin
                saved <= ctrl_rdata[15:0];
                state <= SEQ_WRITE;
              end
              default: begin
                word_q <= 1'b1;
                state  <= word_q ? SEQ_IDLE : SEQ_READ;
              end
            endcase
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // Responder must have closed the previous operation
  a_go_not_in_wait: assert property (
    @(posedge clk) disable iff (reset) ctrl.go |-> !ctrl_wait
  );

  // Wait only stays open while an operation is in flight
  a_wait_in_ack: assert property (
    @(posedge clk) disable iff (reset) ctrl_wait |-> (state == SEQ_HOLD || state == SEQ_ACK)
  );

endmodule

//--- pll_user_regs.sv
`timescale 1ns/1ps

module pll_user_regs #(
  parameter int UIF_DATA_WIDTH = 32
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            uif_go,
  input  pll_reconfig_pkg::uif_mode_e     uif_mode,
  input  pll_reconfig_pkg::uif_addr_t     uif_addr,
  input  logic [UIF_DATA_WIDTH-1:0]       uif_wdata,
  input  pll_reconfig_pkg::refclk_rom_t   refclk_rom,
  input  pll_reconfig_pkg::cgb_rom_t      cgb_rom,
  output logic [UIF_DATA_WIDTH-1:0]       uif_rdata,
  output logic                            uif_addr_err,
  output logic                            start,
  output pll_reconfig_pkg::switch_req_t   req,
  output pll_reconfig_pkg::logical_idx_t  logical_idx
);

  pll_reconfig_pkg::logical_idx_t refclk_idx;
  pll_reconfig_pkg::logical_idx_t cgb_idx;
  logic                           idx_wr;  // Write to offset 0 or 1
  logic                           l2p_rd;  // Read of offset 2 or 3
  logic                           rd_cycle;

  assign rd_cycle = uif_go && (uif_mode == pll_reconfig_pkg::UIF_MODE_RD);
  assign idx_wr   = uif_go && (uif_mode == pll_reconfig_pkg::UIF_MODE_WR) &&
                    (uif_addr[2:1] == 2'b00);
  assign l2p_rd   = rd_cycle && (uif_addr[2:1] == 2'b01);

  // Index source follows the kind of the last request
  assign logical_idx = (req.kind == pll_reconfig_pkg::PLL_CGB) ? cgb_idx : refclk_idx;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      refclk_idx   <= '0;
      cgb_idx      <= '0;
      start        <= 1'b0;
      req          <= '0;
      uif_rdata    <= '0;
      uif_addr_err <= 1'b0;
    end else begin
      start        <= idx_wr || l2p_rd;
      uif_addr_err <= uif_go && (uif_addr > 3'd3);

      // Odd offsets select the CGB side
      if (idx_wr || l2p_rd) begin
        req.kind     <= pll_reconfig_pkg::pll_kind_e'(uif_addr[0]);
        req.l2p_only <= l2p_rd;
      end

      if (idx_wr && !uif_addr[0])
        refclk_idx <= uif_wdata[2:0];
      if (idx_wr && uif_addr[0])
        cgb_idx <= uif_wdata[2:0];

      if (rd_cycle) begin
        case (uif_addr)
          3'd0:    uif_rdata <= UIF_DATA_WIDTH'(refclk_idx);
          3'd1:    uif_rdata <= UIF_DATA_WIDTH'(cgb_idx);
          3'd2:    uif_rdata <= UIF_DATA_WIDTH'(refclk_rom);  // Physical table
          3'd3:    uif_rdata <= UIF_DATA_WIDTH'(cgb_rom);
          default: uif_rdata <= '0;
        endcase
      end
    end
  end

  // User side must respect busy, which covers the pending start
  a_no_go_while_start: assert property (
    @(posedge clk) disable iff (reset) start |-> !uif_go
  );

endmodule

//--- tb_ctrl_responder.sv
`timescale 1ns/1ps

module tb_ctrl_responder (
  input  logic                           clk,
  input  logic                           reset,
  input  pll_reconfig_pkg::ctrl_req_t    ctrl,
  input  logic [1:0]                     wait_len,    // Wait cycles minus one
  input  pll_reconfig_pkg::refclk_rom_t  rom_refclk,  // ROM word at address 1
  input  pll_reconfig_pkg::cgb_rom_t     rom_cgb,     // ROM word at address 2
  output logic                           ctrl_wait,
  output logic [31:0]                    ctrl_rdata
);

  pll_reconfig_pkg::dprio_word_t dprio [64];  // Offsets used all sit below 0x40
  logic [15:0]                   op_log [64];  // {opcode, lock, addr}
  int                            log_cnt;
  logic [2:0]                    remain;
  logic [31:0]                   pending;

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_wait  <= 1'b0;
      ctrl_rdata <= '0;
      remain     <= '0;
      pending    <= '0;
      log_cnt    <= 0;
    end else if (ctrl.go) begin
      ctrl_wait                <= 1'b1;
      remain                   <= 3'(wait_len) + 3'd1;
      op_log[log_cnt[5:0]]     <= {ctrl.opcode, ctrl.lock, ctrl.addr};
      log_cnt                  <= log_cnt + 1;
      case (ctrl.opcode)
        pll_reconfig_pkg::CTRL_OP_ROM_RD:
          if (ctrl.addr == pll_reconfig_pkg::ROM_SEL_REFCLK)
            pending <= 32'(rom_refclk);
          else if (ctrl.addr == pll_reconfig_pkg::ROM_SEL_CGB)
            pending <= 32'(rom_cgb);
          else
            pending <= '0;
        pll_reconfig_pkg::CTRL_OP_RD:
          pending <= 32'(dprio[ctrl.addr[5:0]]);
        default: begin
          dprio[ctrl.addr[5:0]] <= ctrl.wdata[15:0];  // Write lands at go
          pending               <= '0;
        end
      endcase
    end else if (ctrl_wait) begin
      if (remain == 3'd1) begin
        ctrl_wait  <= 1'b0;
        ctrl_rdata <= pending;  // Valid with the falling wait
      end
      remain <= remain - 3'd1;
    end
  end

endmodule

//--- tb_pll_reconfig.sv
`timescale 1ns/1ps

module tb_pll_reconfig;

  localparam int N_IDX     = 6;
  localparam int N_SW      = 8;
  localparam int NUM_TRANS = 2 * N_IDX + 4 * N_SW + 8;

  logic                           clk;
  logic                           reset;
  logic                           uif_go;
  pll_reconfig_pkg::uif_mode_e    uif_mode;
  pll_reconfig_pkg::uif_addr_t    uif_addr;
  logic [31:0]                    uif_wdata;
  pll_reconfig_pkg::lch_t         uif_lch;
  logic                           uif_busy;
  logic [31:0]                    uif_rdata;
  logic                           uif_addr_err;
  pll_reconfig_pkg::ctrl_req_t    ctrl;
  logic                           ctrl_wait;
  logic [31:0]                    ctrl_rdata;
  logic [1:0]                     wait_len;
  pll_reconfig_pkg::refclk_rom_t  rom_refclk;
  pll_reconfig_pkg::cgb_rom_t     rom_cgb;
  pll_reconfig_pkg::dprio_word_t  dprio_model [64];
  logic [15:0]                    lfsr_state = 16'd35;
  int                             checks = 0;
  int                             errors = 0;
  int                             err_start;

  pll_reconfig_top #(
    .UIF_DATA_WIDTH  (32),
    .CTRL_DATA_WIDTH (32)
  ) UUT (
    .clk          (clk),
    .reset        (reset),
    .uif_go       (uif_go),
    .uif_mode     (uif_mode),
    .uif_addr     (uif_addr),
    .uif_wdata    (uif_wdata),
    .uif_lch      (uif_lch),
    .uif_busy     (uif_busy),
    .uif_rdata    (uif_rdata),
    .uif_addr_err (uif_addr_err),
    .ctrl_wait    (ctrl_wait),
    .ctrl_rdata   (ctrl_rdata),
    .ctrl         (ctrl)
  );

  tb_ctrl_responder u_resp (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .wait_len   (wait_len),
    .rom_refclk (rom_refclk),
    .rom_cgb    (rom_cgb),
    .ctrl_wait  (ctrl_wait),
    .ctrl_rdata (ctrl_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (200 * NUM_TRANS + 20) @(posedge clk);
    $display("Timeout: the DUT never finished its transactions");
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers and reference model
  ////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic pll_reconfig_pkg::refclk_cfg_t refclk_decode(
    input pll_reconfig_pkg::refclk_id_t id
  );
    pll_reconfig_pkg::refclk_cfg_t c;
    c = '0;
    if (id <= 5'd10)
      c.iq_clk_sel = 8'(id) + 8'd1;
    else if (id <= 5'd21)
      c.iq_clk_sel = {4'(id - 5'd10), 4'h0};  // Upper nibble
    else if (id == 5'd22)
      c.rrefclk_sel = 1'b1;
    else if (id == 5'd24)
      c.iq_clk_sel = 8'h0C;
    else if (id != 5'd23 && id != 5'd25)
      c.iq_clk_sel = 8'h01;
    return c;
  endfunction

  function automatic pll_reconfig_pkg::cgb_cfg_t cgb_decode(input pll_reconfig_pkg::cgb_id_t id);
    case (id)
      4'd1:    return {2'd0, 1'b0, 6'h13};
      4'd2:    return {2'd0, 1'b0, 6'h20};
      4'd5:    return {2'd0, 1'b0, 6'h12};
      4'd6:    return {2'd0, 1'b0, 6'h10};
      4'd7:    return {2'd0, 1'b0, 6'h11};
      4'd8:    return {2'd2, 1'b1, 6'h28};
      4'd9:    return {2'd1, 1'b1, 6'h24};
      4'd10:   return {2'd0, 1'b1, 6'h24};
      4'd11:   return {2'd1, 1'b1, 6'h28};
      default: return {2'd0, 1'b0, 6'h2C};
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %-16s %s", name, (errors == err_start) ? "ok" : "with errors");
    err_start = errors;
  endtask

  // Issues one user cycle and waits for busy to drop
  task automatic user_cycle(input pll_reconfig_pkg::uif_mode_e mode,
                            input pll_reconfig_pkg::uif_addr_t addr,
                            input logic [31:0] wdata);
    @(posedge clk);
    #1;
    wait_len  = 2'(rand_bits(2));
    uif_lch   = pll_reconfig_pkg::lch_t'(rand_bits(10));
    uif_go    = 1'b1;
    uif_mode  = mode;
    uif_addr  = addr;
    uif_wdata = wdata;
    @(posedge clk);
    #1;
    uif_go = 1'b0;
    while (uif_busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_switch(input pll_reconfig_pkg::pll_kind_e kind, input logic [31:0] wdata);
    logic [2:0]                    slot;
    pll_reconfig_pkg::refclk_cfg_t rc;
    pll_reconfig_pkg::cgb_cfg_t    cc;
    logic [5:0]                    a0;
    logic [5:0]                    a1;
    logic [15:0]                   w0;
    logic [15:0]                   w1;
    logic [15:0]                   exp_ops [5];
    int                            base;
    base = u_resp.log_cnt;
    slot = (wdata[2:0] < 3'd5) ? wdata[2:0] : 3'd0;
    user_cycle(pll_reconfig_pkg::UIF_MODE_WR, pll_reconfig_pkg::uif_addr_t'(kind), wdata);
    if (kind == pll_reconfig_pkg::PLL_REFCLK) begin
      rc = refclk_decode(rom_refclk[slot*5 +: 5]);
      a0 = pll_reconfig_pkg::DPRIO_REFIQ_OFST[5:0];
      a1 = pll_reconfig_pkg::DPRIO_RREF_OFST[5:0];
      w0 = dprio_model[a0];
      w1 = dprio_model[a1];
      w0[10:3] = rc.iq_clk_sel;
      w1[15]   = rc.rrefclk_sel;
      w1[5]    = rc.pcie_mode;
    end else begin
      cc = cgb_decode(rom_cgb[slot*4 +: 4]);
      a0 = pll_reconfig_pkg::DPRIO_CGB_OFST[5:0];
      a1 = pll_reconfig_pkg::DPRIO_CLKNET_OFST[5:0];
      w0 = dprio_model[a0];
      w1 = dprio_model[a1];
      w0[12:11] = cc.x_en;
      w0[5:0]   = cc.clk_sel;
      w1[9]     = cc.clknet_in_en;
    end
    dprio_model[a0] = w0;
    dprio_model[a1] = w1;
    compare("dprio_word0", u_resp.dprio[a0], w0);
    compare("dprio_word1", u_resp.dprio[a1], w1);
    // ROM read and RMW of both words with lock dropped on the last write
    exp_ops[0] = {pll_reconfig_pkg::CTRL_OP_ROM_RD, 1'b1,
                  (kind == pll_reconfig_pkg::PLL_CGB) ? 12'd2 : 12'd1};
    exp_ops[1] = {pll_reconfig_pkg::CTRL_OP_RD, 1'b1, 6'd0, a0};
    exp_ops[2] = {pll_reconfig_pkg::CTRL_OP_WR, 1'b1, 6'd0, a0};
    exp_ops[3] = {pll_reconfig_pkg::CTRL_OP_RD, 1'b1, 6'd0, a1};
    exp_ops[4] = {pll_reconfig_pkg::CTRL_OP_WR, 1'b0, 6'd0, a1};
    compare("ctrl_op_count", u_resp.log_cnt - base, 5);
    for (int i = 0; i < 5; i++)
      compare("ctrl_op", u_resp.op_log[(base + i) % 64], exp_ops[i]);
    compare("ctrl.lch", ctrl.lch, uif_lch);  // Channel of this request
    user_cycle(pll_reconfig_pkg::UIF_MODE_RD, pll_reconfig_pkg::uif_addr_t'(kind), '0);
    compare("uif_rdata", uif_rdata, 32'(wdata[2:0]));
  endtask

  task automatic l2p_readback(input pll_reconfig_pkg::pll_kind_e kind);
    logic [31:0]                 exp;
    pll_reconfig_pkg::uif_addr_t addr;
    int                          base;
    rom_refclk = pll_reconfig_pkg::refclk_rom_t'(rand_bits(25));
    rom_cgb    = pll_reconfig_pkg::cgb_rom_t'(rand_bits(20));
    exp  = (kind == pll_reconfig_pkg::PLL_CGB) ? 32'(rom_cgb) : 32'(rom_refclk);
    addr = 3'd2 + pll_reconfig_pkg::uif_addr_t'(kind);
    base = u_resp.log_cnt;
    user_cycle(pll_reconfig_pkg::UIF_MODE_RD, addr, '0);
    compare("ctrl_op_count", u_resp.log_cnt - base, 1);
    compare("ctrl_op", u_resp.op_log[base % 64], {pll_reconfig_pkg::CTRL_OP_ROM_RD, 1'b0,
            (kind == pll_reconfig_pkg::PLL_CGB) ? 12'd2 : 12'd1});
    compare("ctrl.lch", ctrl.lch, uif_lch);
    user_cycle(pll_reconfig_pkg::UIF_MODE_RD, addr, '0);
    compare("uif_rdata", uif_rdata, exp);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    uif_go     = 1'b0;
    uif_mode   = pll_reconfig_pkg::UIF_MODE_RD;
    uif_addr   = '0;
    uif_wdata  = '0;
    uif_lch    = '0;
    wait_len   = '0;
    rom_refclk = pll_reconfig_pkg::refclk_rom_t'(rand_bits(25));
    rom_cgb    = pll_reconfig_pkg::cgb_rom_t'(rand_bits(20));
    err_start  = 0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < 64; i++) begin
      dprio_model[i]  = 16'(rand_bits(16));  // DPRIO preload
      u_resp.dprio[i] = dprio_model[i];
    end

    compare("uif_busy", uif_busy, 0);
    compare("ctrl.go", ctrl.go, 0);
    compare("ctrl.lock", ctrl.lock, 0);
    compare("uif_rdata", uif_rdata, 0);
    compare("uif_addr_err", uif_addr_err, 0);
    report_test("reset");

    for (int i = 0; i < N_IDX; i++)
      run_switch(pll_reconfig_pkg::pll_kind_e'(i % 2), rand_bits(32));
    report_test("index_regs");

    for (int i = 0; i < N_SW; i++) begin
      rom_refclk = pll_reconfig_pkg::refclk_rom_t'(rand_bits(25));
      run_switch(pll_reconfig_pkg::PLL_REFCLK, rand_bits(32));
    end
    report_test("refclk_switch");

    // First three indexes land outside the table
    for (int i = 0; i < N_SW; i++) begin
      rom_cgb = pll_reconfig_pkg::cgb_rom_t'(rand_bits(20));
      if (i < 3)
        run_switch(pll_reconfig_pkg::PLL_CGB, {29'(rand_bits(29)), 3'(5 + i)});
      else
        run_switch(pll_reconfig_pkg::PLL_CGB, rand_bits(32));
    end
    report_test("cgb_switch");

    l2p_readback(pll_reconfig_pkg::PLL_REFCLK);
    l2p_readback(pll_reconfig_pkg::PLL_CGB);
    report_test("l2p_readback");

    for (int a = 4; a < 8; a++) begin
      user_cycle(pll_reconfig_pkg::UIF_MODE_RD, pll_reconfig_pkg::uif_addr_t'(a), '0);
      compare("uif_addr_err", uif_addr_err, 1);
      compare("uif_rdata", uif_rdata, 0);
      @(posedge clk);
      #1;
      compare("uif_addr_err", uif_addr_err, 0);  // Only one cycle
    end
    report_test("addr_error");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
